// File: st_mem_bus.f
rtl/st_bus_pkg.sv
rtl/bus_cycle_timer.sv
rtl/upload_fsm.sv
rtl/st_mem_map.sv
rtl/viking_detect.sv
rtl/sdram_req_mux.sv
rtl/st_mem_bus.sv
tests/st_mem_bus_tb.sv

// File: Bender.yml
package:
  name: st_mem_bus

sources:
  - rtl/st_bus_pkg.sv
  - rtl/bus_cycle_timer.sv
  - rtl/upload_fsm.sv
  - rtl/st_mem_map.sv
  - rtl/viking_detect.sv
  - rtl/sdram_req_mux.sv
  - rtl/st_mem_bus.sv
  - target: test
    files:
      - tests/st_mem_bus_tb.sv

// File: tests/st_mem_bus_vectors.txt
# name cyc cfg cpu(as ras we uds lds rom2) caddr cdata blit(has rd wr) baddr bdata vrd vaddr
#  dio(dl strobe) daddr ddata | exp(oe we uds lds) eaddr edata erom flags(tos vact)
r512p 0 00 011110 03ffff 0000 000 000000 0000 0 000000 00 000000 0000 0011 03ffff 0000 03ffff 00
r512i 1 00 001110 03ffff 0000 000 000000 0000 0 000000 00 000000 0000 1011 03ffff 0000 03ffff 00
r512q 0 00 011110 040000 0000 000 000000 0000 0 000000 00 000000 0000 0011 040000 0000 040000 00
r512o 1 00 001110 040000 0000 000 000000 0000 0 000000 00 000000 0000 0011 040000 0000 040000 00
r1mp 0 04 011110 07ffff 0000 000 000000 0000 0 000000 00 000000 0000 0011 07ffff 0000 07ffff 00
r1mi 1 04 001110 07ffff 0000 000 000000 0000 0 000000 00 000000 0000 1011 07ffff 0000 07ffff 00
r1mq 0 04 011110 080000 0000 000 000000 0000 0 000000 00 000000 0000 0011 080000 0000 080000 00
r1mo 1 04 001110 080000 0000 000 000000 0000 0 000000 00 000000 0000 0011 080000 0000 080000 00
r2mp 0 08 011110 0fffff 0000 000 000000 0000 0 000000 00 000000 0000 0011 0fffff 0000 0fffff 00
r2mi 1 08 001110 0fffff 0000 000 000000 0000 0 000000 00 000000 0000 1011 0fffff 0000 0fffff 00
r2mq 0 08 011110 100000 0000 000 000000 0000 0 000000 00 000000 0000 0011 100000 0000 100000 00
r2mo 1 08 001110 100000 0000 000 000000 0000 0 000000 00 000000 0000 0011 100000 0000 100000 00
r4mp 0 0c 011110 1fffff 0000 000 000000 0000 0 000000 00 000000 0000 0011 1fffff 0000 1fffff 00
r4mi 1 0c 001110 1fffff 0000 000 000000 0000 0 000000 00 000000 0000 1011 1fffff 0000 1fffff 00
r4mq 0 0c 011110 200000 0000 000 000000 0000 0 000000 00 000000 0000 0011 200000 0000 200000 00
r4mo 1 0c 001110 200000 0000 000 000000 0000 0 000000 00 000000 0000 0011 200000 0000 200000 00
r8mp 0 10 011110 3fffff 0000 000 000000 0000 0 000000 00 000000 0000 0011 3fffff 0000 3fffff 00
r8mi 1 10 001110 3fffff 0000 000 000000 0000 0 000000 00 000000 0000 1011 3fffff 0000 3fffff 00
r8mq 0 10 011110 400000 0000 000 000000 0000 0 000000 00 000000 0000 0011 400000 0000 400000 00
r8mo 1 10 001110 400000 0000 000 000000 0000 0 000000 00 000000 0000 0011 400000 0000 400000 00
r14p 0 14 011110 6fffff 0000 000 000000 0000 0 000000 00 000000 0000 0011 6fffff 0000 6fffff 00
r14i 1 14 001110 6fffff 0000 000 000000 0000 0 000000 00 000000 0000 1011 6fffff 0000 6fffff 00
r14q 0 14 011110 700000 0000 000 000000 0000 0 000000 00 000000 0000 0011 700000 0000 700000 00
r14o 1 14 001110 700000 0000 000 000000 0000 0 000000 00 000000 0000 0011 700000 0000 700000 00
wrp 0 10 010110 001000 c0de 000 000000 0000 0 000000 00 000000 0000 0011 001000 c0de 001000 00
wri 1 10 000110 001000 c0de 000 000000 0000 0 000000 00 000000 0000 0111 001000 c0de 001000 00
up_pre 0 10 111000 000000 0000 000 000000 0000 0 000000 10 7e0000 beef 0000 000000 0000 000000 10
up_tog 3 10 111000 000000 0000 000 000000 0000 0 000000 11 7e0000 beef 0000 000000 0000 000000 10
up_wr 1 10 111000 000000 0000 000 000000 0000 0 000000 11 7e0000 beef 0111 7e0000 beef 000000 10
rom_hi 3 10 111001 001234 0000 000 000000 0000 0 000000 11 7e0000 beef 0000 001234 0000 7e1234 10
up_nowr 1 10 111000 000000 0000 000 000000 0000 0 000000 11 7e0000 beef 0011 7e0000 beef 000000 10
up_e 3 10 111000 000000 0000 000 000000 0000 0 000000 11 700000 beef 0000 000000 0000 000000 00
rom_lo 3 10 111001 001234 0000 000 000000 0000 0 000000 01 700000 beef 0000 001234 0000 701234 00
bl_pre 0 10 011110 000100 0000 000 000000 0000 0 000000 01 000000 0000 0011 000100 0000 000100 00
bl_rd 1 10 001110 000100 0000 110 012340 5555 0 000000 01 000000 0000 1011 012340 5555 000100 00
bl_pre2 0 10 011110 000100 0000 000 000000 0000 0 000000 01 000000 0000 0011 000100 0000 000100 00
bl_dl 1 10 001110 000100 0000 101 012340 5555 0 000000 11 010000 a5a5 0011 010000 a5a5 000100 00
bl_end 3 10 111000 000000 0000 000 000000 0000 0 000000 01 010000 a5a5 0000 000000 0000 000000 00
loop_14m 0 16 011000 600000 0000 000 000000 0000 0 000000 01 000000 0000 0000 600000 0000 600000 00
loop_vik 0 12 011000 600000 0000 000 000000 0000 0 000000 01 000000 0000 0000 600000 0000 600000 01
vik_rd 2 12 111000 000000 0000 000 000000 0000 1 0abcd0 01 000000 0000 1011 0abcd0 0000 000000 01
vik_cpu 1 12 111000 000000 0000 000 000000 0000 1 0abcd0 01 000000 0000 0000 000000 0000 000000 01

// File: tests/st_mem_bus_tb.sv
// testbench for the st memory bus, vector driven checks
// reset and timer, ram window, upload, rom remap, blitter, viking
module st_mem_bus_tb
	import st_bus_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int loop_clks = 1040;      // 260 bus phases, past viking_thresh
	localparam string vec_file = "tests/st_mem_bus_vectors.txt";

	// one vector line
	typedef struct {
		string       name;
		logic [1:0]  cyc;
		logic [4:0]  cfg;
		logic [5:0]  cpuctl;               // as_n ras_n we_n uds lds rom2
		logic [22:0] caddr;
		logic [15:0] cdata;
		logic [2:0]  blctl;                // has_bus read write
		logic [22:0] baddr;
		logic [15:0] bdata;
		logic        vrd;
		logic [22:0] vaddr;
		logic [1:0]  dioctl;               // download strobe
		logic [22:0] daddr;
		logic [15:0] ddata;
		logic [3:0]  ectl;                 // oe we uds lds
		logic [22:0] eaddr;
		logic [15:0] edata;
		logic [22:0] erom;
		logic [1:0]  eflags;               // tos192k viking_active
	} vec_t;

	logic       clk_32;
	logic       xsint;
	sys_cfg_t   cfg_i;
	cpu_req_t   cpu_i;
	blit_req_t  blit_i;
	vik_req_t   vik_i;
	dio_req_t   dio_i;
	sdram_req_t sdram_req_o;
	waddr_t     rom_addr_o;
	bus_cycle_t bus_cycle_o;
	logic       tos192k_o;
	logic       viking_active_o;

	vec_t       vecs[$];
	int         seed;
	int         n_loops;
	bit         vecs_ready;

	st_mem_bus u_st_mem_bus (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.cfg_i           (cfg_i),
		.cpu_i           (cpu_i),
		.blit_i          (blit_i),
		.vik_i           (vik_i),
		.dio_i           (dio_i),
		.sdram_req_o     (sdram_req_o),
		.rom_addr_o      (rom_addr_o),
		.bus_cycle_o     (bus_cycle_o),
		.tos192k_o       (tos192k_o),
		.viking_active_o (viking_active_o)
	);

	initial begin
		clk_32 = 1'b0;
		forever #50 clk_32 = ~clk_32;     // 100 ns period
	end

	// compare and stop on the first mismatch, x counts as wrong
	task automatic check_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		if (exp !== act) begin
			$display("Fail %s expected %h actual %h", name, exp, act);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic read_vectors();
		int    fd;
		int    cnt;
		string line;
		vec_t  v;
		fd = $fopen(vec_file, "r");
		if (fd == 0) begin
			$display("could not open the vector file");
			$display("Something failed");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;                     // blank or column notes
			cnt = $sscanf(line,
				"%s %h %h %b %h %h %b %h %h %h %h %b %h %h %b %h %h %h %b",
				v.name, v.cyc, v.cfg, v.cpuctl, v.caddr, v.cdata, v.blctl,
				v.baddr, v.bdata, v.vrd, v.vaddr, v.dioctl, v.daddr, v.ddata,
				v.ectl, v.eaddr, v.edata, v.erom, v.eflags);
			if (cnt != 19) begin
				$display("malformed line in the vector file: %s", line);
				$display("Something failed");
				$fatal(1);
			end
			if (v.name.substr(0, 3) == "loop")
				n_loops++;
			vecs.push_back(v);
		end
		$fclose(fd);
	endtask

	task automatic apply_inputs(input vec_t v);
		cfg_i          = sys_cfg_t'(v.cfg);
		cpu_i.as_n     = v.cpuctl[5];
		cpu_i.ras_n    = v.cpuctl[4];
		cpu_i.we_n     = v.cpuctl[3];
		cpu_i.uds      = v.cpuctl[2];
		cpu_i.lds      = v.cpuctl[1];
		cpu_i.rom2_sel = v.cpuctl[0];
		cpu_i.addr     = v.caddr;
		cpu_i.wdata    = v.cdata;
		blit_i.has_bus = v.blctl[2];
		blit_i.read    = v.blctl[1];
		blit_i.write   = v.blctl[0];
		blit_i.addr    = v.baddr;
		blit_i.wdata   = v.bdata;
		vik_i.read     = v.vrd;
		vik_i.vaddr    = v.vaddr;
		dio_i.download = v.dioctl[1];
		dio_i.strobe   = v.dioctl[0];
		dio_i.addr     = v.daddr;
		dio_i.data     = v.ddata;
	endtask

	// wait for the bus phase, drive, check one clock later
	task automatic run_step(input vec_t v);
		while (bus_cycle_o != bus_cycle_t'(v.cyc)) begin
			@(posedge clk_32);
			#10;
		end
		apply_inputs(v);
		@(posedge clk_32);
		#1;
		check_value({v.name, " addr"}, 64'(v.eaddr), 64'(sdram_req_o.addr));
		check_value({v.name, " ctl"}, 64'(v.ectl), 64'({sdram_req_o.oe, sdram_req_o.we,
			sdram_req_o.uds, sdram_req_o.lds}));
		check_value({v.name, " wdata"}, 64'(v.edata), 64'(sdram_req_o.wdata));
		check_value({v.name, " rom_addr"}, 64'(v.erom), 64'(rom_addr_o));
		check_value({v.name, " flags"}, 64'(v.eflags), 64'({tos192k_o, viking_active_o}));
		#9;                               // back to 10 ns after the edge
	endtask

	// cpu sits on the viking range with random data, no ras
	task automatic run_viking_loop(input vec_t v);
		apply_inputs(v);
		for (int i = 0; i < loop_clks; i++) begin
			cpu_i.wdata = $random(seed);
			@(posedge clk_32);
			#1;
			check_value({v.name, " addr"}, 64'(v.eaddr), 64'(sdram_req_o.addr));
			check_value({v.name, " oe/we"}, 64'(0), 64'({sdram_req_o.oe, sdram_req_o.we}));
			check_value({v.name, " wdata"}, 64'(cpu_i.wdata), 64'(sdram_req_o.wdata));
			#9;
		end
		check_value({v.name, " active"}, 64'(v.eflags[0]), 64'(viking_active_o));
	endtask

	// reset state, then the bus phase stepping once per 4 clocks
	task automatic check_timer();
		bus_cycle_t prev;
		int         waited;
		check_value("reset strobes", 64'(0), 64'({sdram_req_o.oe, sdram_req_o.we,
			sdram_req_o.uds, sdram_req_o.lds}));
		check_value("reset tos192k", 64'(0), 64'(tos192k_o));
		check_value("reset viking", 64'(0), 64'(viking_active_o));
		check_value("reset cycle", 64'(cyc_precycle), 64'(bus_cycle_o));
		prev   = bus_cycle_o;
		waited = 0;
		while (bus_cycle_o == prev && waited < 8) begin
			@(posedge clk_32);
			#10;
			waited++;
		end
		check_value("first step", 64'(cyc_cpu), 64'(bus_cycle_o));
		check_value("first step clocks", 64'(4), 64'(waited));
		for (int i = 0; i < 4; i++) begin
			prev = bus_cycle_o;
			repeat (4) @(posedge clk_32);
			#1;
			check_value("cycle step", 64'((prev + 1) % 4), 64'(bus_cycle_o));
			#9;
		end
	endtask

	initial begin
		seed       = 67;
		n_loops    = 0;
		vecs_ready = 1'b0;
		xsint      = 1'b0;
		cfg_i      = '0;
		cpu_i      = '0;
		cpu_i.as_n = 1'b1;
		cpu_i.ras_n = 1'b1;               // idle high, no false edge
		cpu_i.we_n = 1'b1;
		blit_i     = '0;
		vik_i      = '0;
		dio_i      = '0;
		read_vectors();
		vecs_ready = 1'b1;
		repeat (2) @(posedge clk_32);
		#10;
		xsint = 1'b1;
		check_timer();
		foreach (vecs[i]) begin
			if (vecs[i].name.substr(0, 3) == "loop")
				run_viking_loop(vecs[i]);
			else
				run_step(vecs[i]);
		end
		$display("Everything OK");
		$finish;
	end

	// watchdog sized from vector count and loop length
	initial begin
		wait (vecs_ready);
		repeat (vecs.size() * 8 + n_loops * loop_clks + 300) @(posedge clk_32);
		$display("simulation timed out waiting for the bus");
		$display("Something failed");
		$fatal(1);
	end

endmodule

// File: rtl/st_mem_bus.sv
// st memory bus top, timer, upload, memory map, viking detect, request mux
module st_mem_bus
	import st_bus_pkg::*;
(
	input  logic       clk_32,
	input  logic       xsint,
	input  sys_cfg_t   cfg_i,
	input  cpu_req_t   cpu_i,
	input  blit_req_t  blit_i,
	input  vik_req_t   vik_i,
	input  dio_req_t   dio_i,
	output sdram_req_t sdram_req_o,
	output waddr_t     rom_addr_o,
	output bus_cycle_t bus_cycle_o,
	output logic       tos192k_o,
	output logic       viking_active_o
);

	logic en8;                           // 8 MHz bus enable
	logic data_wr;                       // upload write window
	logic ram_en;                        // cpu address inside st-ram

	bus_cycle_timer u_bus_cycle_timer (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.en8_o       (en8),
		.bus_cycle_o (bus_cycle_o)
	);

	upload_fsm u_upload_fsm (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.en8_i       (en8),
		.bus_cycle_i (bus_cycle_o),
		.dio_i       (dio_i),
		.data_wr_o   (data_wr),
		.tos192k_o   (tos192k_o)
	);

	st_mem_map u_st_mem_map (
		.cfg_i      (cfg_i),
		.cpu_i      (cpu_i),
		.tos192k_i  (tos192k_o),
		.ram_en_o   (ram_en),
		.rom_addr_o (rom_addr_o)
	);

	viking_detect u_viking_detect (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.en8_i           (en8),
		.cfg_i           (cfg_i),
		.cpu_i           (cpu_i),
		.viking_active_o (viking_active_o)
	);

	sdram_req_mux u_sdram_req_mux (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.bus_cycle_i     (bus_cycle_o),
		.cpu_i           (cpu_i),
		.blit_i          (blit_i),
		.vik_i           (vik_i),
		.dio_i           (dio_i),
		.data_wr_i       (data_wr),
		.ram_en_i        (ram_en),
		.viking_active_i (viking_active_o),
		.sdram_req_o     (sdram_req_o)
	);

endmodule

// File: rtl/sdram_req_mux.sv
// per bus cycle choice of sdram request source
// upload, blitter, viking fetch or cpu, registered, with ras edge detect
module sdram_req_mux
	import st_bus_pkg::*;
(
	input  logic       clk_32,
	input  logic       xsint,
	input  bus_cycle_t bus_cycle_i,
	input  cpu_req_t   cpu_i,
	input  blit_req_t  blit_i,
	input  vik_req_t   vik_i,
	input  dio_req_t   dio_i,
	input  logic       data_wr_i,
	input  logic       ram_en_i,
	input  logic       viking_active_i,
	output sdram_req_t sdram_req_o
);

	logic       ras_n_d;                 // ras one clock back
	logic       ras_fall;
	logic       cpu_oe;
	logic       cpu_we;
	logic       cpu_cyc;
	logic       vik_cyc;
	sdram_req_t req_nxt;
	sdram_req_t req_q;

	assign cpu_cyc  = (bus_cycle_i == cyc_cpu);
	assign vik_cyc  = (bus_cycle_i == cyc_viking);
	assign ras_fall = ras_n_d & ~cpu_i.ras_n;

	// no read at address 0, reset vector comes from rom
	assign cpu_oe = ras_fall & cpu_i.we_n & (|cpu_i.addr) & ram_en_i;
	assign cpu_we = ras_fall & ~cpu_i.we_n & ram_en_i;

	always_comb begin
		if (cpu_cyc && dio_i.download) begin
			req_nxt.addr  = dio_i.addr;         // upload beats everything
			req_nxt.oe    = 1'b0;
			req_nxt.we    = data_wr_i;
			req_nxt.uds   = 1'b1;
			req_nxt.lds   = 1'b1;
			req_nxt.wdata = dio_i.data;
		end else if (cpu_cyc && blit_i.has_bus) begin
			req_nxt.addr  = blit_i.addr;        // blitter bypasses the mmu
			req_nxt.oe    = blit_i.read;
			req_nxt.we    = blit_i.write;
			req_nxt.uds   = 1'b1;
			req_nxt.lds   = 1'b1;
			req_nxt.wdata = blit_i.wdata;
		end else if (vik_cyc && viking_active_i && vik_i.read) begin
			req_nxt.addr  = vik_i.vaddr;        // video fetch in shifter slot
			req_nxt.oe    = 1'b1;
			req_nxt.we    = 1'b0;
			req_nxt.uds   = 1'b1;
			req_nxt.lds   = 1'b1;
			req_nxt.wdata = cpu_i.wdata;
		end else begin
			req_nxt.addr  = cpu_i.addr;
			req_nxt.oe    = cpu_oe;
			req_nxt.we    = cpu_we;
			req_nxt.uds   = cpu_i.uds;
			req_nxt.lds   = cpu_i.lds;
			req_nxt.wdata = cpu_i.wdata;
		end
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ras_n_d <= 1'b1;                    // idle high, no false edge
			req_q   <= '0;
		end else begin
			ras_n_d <= cpu_i.ras_n;
			req_q   <= req_nxt;
		end
	end

	assign sdram_req_o = req_q;

	// controller takes one direction per request
	assert property (@(posedge clk_32) disable iff (!xsint)
		!(sdram_req_o.oe && sdram_req_o.we));

endmodule

// File: rtl/viking_detect.sv
// viking card driver detect, counts accesses to the video range
module viking_detect
	import st_bus_pkg::*;
(
	input  logic     clk_32,
	input  logic     xsint,
	input  logic     en8_i,
	input  sys_cfg_t cfg_i,
	input  cpu_req_t cpu_i,
	output logic     viking_active_o
);

	logic       card_en;
	logic       tag_hit;
	logic [7:0] in_use;                  // saturating access count
	logic       active;

	// max 8M st-ram with the card, steroids moves it up and allows 14M
	assign card_en = (cfg_i.viking_en && (cfg_i.mem_size <= mem_8m)) || cfg_i.steroids;
	assign tag_hit = cpu_i.addr[22:17] == (cfg_i.steroids ? viking_base_hi : viking_base_lo);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			in_use <= '0;
			active <= 1'b0;
		end else begin
			// one count per bus clock with the cpu on the range
			if (en8_i && !cpu_i.as_n && card_en && tag_hit && (in_use != viking_thresh))
				in_use <= in_use + 8'd1;
			active <= (in_use == viking_thresh);    // probes alone do not switch
		end
	end

	assign viking_active_o = active;

	// count sticks at the threshold
	assert property (@(posedge clk_32) disable iff (!xsint)
		(in_use == viking_thresh) |=> (in_use == viking_thresh));

endmodule

// File: rtl/st_mem_map.sv
// ram size window check and tos rom address remap
module st_mem_map
	import st_bus_pkg::*;
(
	input  sys_cfg_t cfg_i,
	input  cpu_req_t cpu_i,
	input  logic     tos192k_i,
	output logic     ram_en_o,
	output waddr_t   rom_addr_o
);

	// st-ram ends at 512k << mem_size, 14M stops short of the rom area
	always_comb begin
		case (cfg_i.mem_size)
			mem_512k: ram_en_o = (cpu_i.addr[22:18] == '0);
			mem_1m:   ram_en_o = (cpu_i.addr[22:19] == '0);
			mem_2m:   ram_en_o = (cpu_i.addr[22:20] == '0);
			mem_4m:   ram_en_o = (cpu_i.addr[22:21] == '0);
			mem_8m:   ram_en_o = !cpu_i.addr[22];
			mem_14m:  ram_en_o = (cpu_i.addr < 23'h700000);  // below $e00000
			default:  ram_en_o = 1'b0;                        // unused codes
		endcase
	end

	// 256k tos sits at $e00000, 192k tos at $fc0000
	always_comb begin
		if (cpu_i.rom2_sel && tos192k_i)
			rom_addr_o = {4'hf, 2'b11, cpu_i.addr[16:0]};
		else if (cpu_i.rom2_sel)
			rom_addr_o = {4'he, 2'b00, cpu_i.addr[16:0]};
		else
			rom_addr_o = cpu_i.addr;                          // plain cpu address
	end

endmodule

// File: rtl/upload_fsm.sv
// tos/cartridge upload from the io controller
// strobe toggle detect, ram write window and 192k tos flag
module upload_fsm
	import st_bus_pkg::*;
(
	input  logic       clk_32,
	input  logic       xsint,
	input  logic       en8_i,
	input  bus_cycle_t bus_cycle_i,
	input  dio_req_t   dio_i,
	output logic       data_wr_o,
	output logic       tos192k_o
);

	upload_state_t state;
	logic          strobe_d;             // strobe level at last precycle
	logic          tos192k;
	logic          pre_en;
	logic          toggle;

	assign pre_en = en8_i && (bus_cycle_i == cyc_precycle);
	assign toggle = dio_i.strobe ^ strobe_d;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			state    <= up_idle;
			strobe_d <= 1'b0;
		end else begin
			if (pre_en)
				strobe_d <= dio_i.strobe;   // tracked even when idle
			case (state)
				up_idle: begin
					if (dio_i.download)
						state <= up_wait;
				end
				up_wait: begin
					if (!dio_i.download)
						state <= up_idle;
					else if (pre_en && toggle)
						state <= up_write;      // new word waiting
				end
				up_write: begin
					// hold through the cpu cycle, leave when viking phase starts
					if (!dio_i.download)
						state <= up_idle;
					else if (en8_i && (bus_cycle_i == cyc_viking))
						state <= up_wait;
				end
				default: state <= up_idle;
			endcase
		end
	end

	// 192k tos lives at $fc0000, 256k tos at $e00000
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k <= 1'b0;
		end else if (dio_i.download) begin
			if (dio_i.addr[22:17] == 6'h3f)
				tos192k <= 1'b1;
			else if (dio_i.addr[22:19] == 4'he)
				tos192k <= 1'b0;
		end
	end

	assign data_wr_o = (state == up_write);
	assign tos192k_o = tos192k;

	// write window only while a download is running
	assert property (@(posedge clk_32) disable iff (!xsint)
		data_wr_o |-> dio_i.download);

endmodule

// File: rtl/bus_cycle_timer.sv
// 8 MHz enable from clk_32 and the four phase bus cycle counter
module bus_cycle_timer
	import st_bus_pkg::*;
(
	input  logic       clk_32,
	input  logic       xsint,
	output logic       en8_o,
	output bus_cycle_t bus_cycle_o
);

	logic [1:0] prescale;               // clk_32 divider
	logic       en8;
	bus_cycle_t bus_cycle;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			prescale  <= '0;
			en8       <= 1'b0;
			bus_cycle <= cyc_precycle;
		end else begin
			prescale <= prescale + 2'd1;    // wraps on its own at 3
			en8      <= (prescale == prescale_max);
			// phase steps together with en8, so en8 marks a cycle start
			if (prescale == prescale_max)
				bus_cycle <= bus_cycle_t'(bus_cycle + 2'd1);
		end
	end

	assign en8_o       = en8;
	assign bus_cycle_o = bus_cycle;

	// one clock wide pulse, never back to back
	assert property (@(posedge clk_32) disable iff (!xsint)
		en8_o |=> !en8_o);

endmodule

// File: rtl/st_bus_pkg.sv
// shared widths, address tags, bus cycle and memory size codes
// request structs for cpu, blitter, viking, data io and sdram
package st_bus_pkg;

	localparam int addr_w = 23;             // word address, byte bits 23..1
	localparam int data_w = 16;

	typedef logic [data_w-1:0] word_t;
	typedef logic [addr_w-1:0] waddr_t;

	// four phases of the 8 MHz bus
	typedef enum logic [1:0] {
		cyc_precycle = 2'd0,
		cyc_cpu      = 2'd1,
		cyc_viking   = 2'd2,                // shared with shifter
		cyc_idle     = 2'd3
	} bus_cycle_t;

	typedef enum logic [1:0] {
		up_idle,
		up_wait,
		up_write
	} upload_state_t;

	typedef enum logic [2:0] {
		mem_512k = 3'd0,
		mem_1m   = 3'd1,
		mem_2m   = 3'd2,
		mem_4m   = 3'd3,
		mem_8m   = 3'd4,
		mem_14m  = 3'd5
	} mem_size_t;

	localparam logic [5:0] viking_base_lo = 6'h30;  // $c00000
	localparam logic [5:0] viking_base_hi = 6'h3a;  // $e80000, steroids
	localparam logic [7:0] viking_thresh  = 8'd255; // driver considered loaded
	localparam logic [1:0] prescale_max   = 2'd3;   // 32 MHz / 4

	typedef struct packed {
		mem_size_t mem_size;
		logic      viking_en;
		logic      steroids;                // ste and mste both set
	} sys_cfg_t;

	typedef struct packed {
		waddr_t addr;
		logic   as_n;
		logic   ras_n;
		logic   we_n;
		logic   uds;
		logic   lds;
		word_t  wdata;
		logic   rom2_sel;                   // tos rom window
	} cpu_req_t;

	typedef struct packed {
		logic   has_bus;
		logic   read;
		logic   write;
		waddr_t addr;
		word_t  wdata;
	} blit_req_t;

	typedef struct packed {
		logic   read;
		waddr_t vaddr;
	} vik_req_t;

	typedef struct packed {
		logic   download;
		logic   strobe;                     // toggles once per word
		waddr_t addr;
		word_t  data;
	} dio_req_t;

	typedef struct packed {
		waddr_t addr;
		logic   oe;
		logic   we;
		logic   uds;
		logic   lds;
		word_t  wdata;
	} sdram_req_t;

endpackage
